//--- Bender.yml
package:
  name: mips_ex

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/mips_ex_pkg.sv
      - verilog/ex_decode.sv
      - verilog/ex_alu.sv
      - verilog/ex_hilo_wb.sv
      - verilog/mips_ex_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_mips_ex.sv

//--- include/tb_mips_ex_tasks.svh
`ifndef TB_MIPS_EX_TASKS_SVH
`define TB_MIPS_EX_TASKS_SVH

task automatic stop_on_error();
	$display("TESTBENCH FAILED");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic check_word(input string name, input word_t got, input word_t want);
	if (got !== want) begin
		$display("error: %s got %h expected %h", name, got, want);
		stop_on_error();
	end
endtask

task automatic check_res(input string name, input ex_res_t got, input ex_res_t want);
	ex_res_t got_m;
	ex_res_t want_m;
	got_m = got;
	want_m = want;
	// wdata only matters when the register is written
	if (want.wreg) begin
		check_word({name, ".wdata"}, got.wdata, want.wdata);
	end
	got_m.wdata = '0;
	want_m.wdata = '0;
	if (got_m !== want_m) begin
		$display("error: %s got %h expected %h", name, got, want);
		stop_on_error();
	end
endtask

task automatic check_arrival();
	ex_res_t want;
	int      due;
	if (res.valid) begin
		if (exp_q.size() == 0) begin
			$display("a result arrived at cycle %0d with no operation in flight", cyc);
			stop_on_error();
		end
		want = exp_q.pop_front();
		due = due_q.pop_front();
		if (due != cyc) begin
			$display("a result arrived at cycle %0d but was due at cycle %0d", cyc, due);
			stop_on_error();
		end
		check_res("res_o", res, want);
	end
endtask

// outputs are sampled and inputs driven 1 ns after the edge
task automatic step_cycle();
	@(posedge clk);
	cyc = cyc + 1;
	#1;
	check_arrival();
	req = '0;
endtask

task automatic idle_cycles(input int n);
	repeat (n) step_cycle();
endtask

task automatic issue_op(input alu_op_e op, input word_t a, input word_t b);
	ex_res_t want;
	logic    writes;
	writes = 1'b1;
	step_cycle();
	next_wd = next_wd + 1'b1;
	case (op)
		OP_MULT: begin
			writes = 1'b0;
		end
		OP_MULTU: begin
			writes = 1'b0;
		end
		OP_MTHI: begin
			writes = 1'b0;
		end
		OP_MTLO: begin
			writes = 1'b0;
		end
		default: begin
			writes = 1'b1;
		end
	endcase
	req.valid = 1'b1;
	req.op = op;
	req.reg1 = a;
	req.reg2 = b;
	req.wd = next_wd;
	req.wreg = writes;
	want.valid = 1'b1;
	want.wd = next_wd;
	want.ovf = ((op == OP_ADD) || (op == OP_SUB)) && add_overflows(a, b, op == OP_SUB);
	want.wreg = writes && !want.ovf;
	want.wdata = model_word(op, a, b);
	exp_q.push_back(want);
	due_q.push_back(cyc + 3);
	// program order view of hi/lo
	case (op)
		OP_MULT:  {m_hi, m_lo} = product64(a, b, 1'b1);
		OP_MULTU: {m_hi, m_lo} = product64(a, b, 1'b0);
		OP_MTHI:  m_hi = a;
		OP_MTLO:  m_lo = a;
		default:  ;
	endcase
endtask

task automatic wait_results();
	int waited;
	waited = 0;
	while (exp_q.size() != 0) begin
		if (waited == RESULT_TIMEOUT) begin
			$display("timeout: the result due at cycle %0d never arrived", due_q[0]);
			stop_on_error();
		end
		step_cycle();
		waited++;
	end
endtask

`endif

//--- bench/tb_mips_ex.sv
`timescale 1ns/1ps
`include "mips_ex_consts.svh"

module tb_mips_ex import mips_ex_pkg::*; ();

	localparam int RESULT_TIMEOUT = 16;

	logic     clk;
	logic     rst_n_i;
	ex_req_t  req;
	ex_res_t  res;
	int       cyc;
	integer   seed;
	word_t    m_hi;
	word_t    m_lo;
	regaddr_t next_wd;
	ex_res_t  exp_q[$];
	int       due_q[$];

	mips_ex_top dut0 (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (req),
		.res_o   (res)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [`EX_CNT_W-1:0] count_leading(input word_t v, input logic bit_val);
		int n;
		n = 0;
		while (n < `EX_WORD_W && v[`EX_WORD_W-1-n] == bit_val) begin
			n++;
		end
		return n[`EX_CNT_W-1:0];
	endfunction

	function automatic logic [2*`EX_WORD_W-1:0] product64(input word_t a, input word_t b,
		input logic is_signed);
		longint sa;
		longint sb;
		sa = $signed(a);
		sb = $signed(b);
		if (is_signed) begin
			return sa * sb;
		end
		return {{`EX_WORD_W{1'b0}}, a} * {{`EX_WORD_W{1'b0}}, b};
	endfunction

	// exact sum outside the signed 32-bit range
	function automatic logic add_overflows(input word_t a, input word_t b, input logic sub);
		longint sa;
		longint sb;
		longint s;
		sa = $signed(a);
		sb = $signed(b);
		s = sub ? sa - sb : sa + sb;
		return (s > 64'sd2147483647) || (s < -64'sd2147483648);
	endfunction

	function automatic word_t model_word(input alu_op_e op, input word_t a, input word_t b);
		logic [2*`EX_WORD_W-1:0] prod;
		prod = product64(a, b, 1'b1);
		case (op)
			OP_OR:   return a | b;
			OP_AND:  return a & b;
			OP_NOR:  return ~(a | b);
			OP_XOR:  return a ^ b;
			OP_SLL:  return b << a[`EX_SHAMT_W-1:0];
			OP_SRL:  return b >> a[`EX_SHAMT_W-1:0];
			OP_SRA:  return $signed(b) >>> a[`EX_SHAMT_W-1:0];
			OP_ADD, OP_ADDU: return a + b;
			OP_SUB, OP_SUBU: return a - b;
			OP_SLT:  return {{(`EX_WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
			OP_SLTU: return {{(`EX_WORD_W-1){1'b0}}, a < b};
			OP_CLZ:  return {{(`EX_WORD_W-`EX_CNT_W){1'b0}}, count_leading(a, 1'b0)};
			OP_CLO:  return {{(`EX_WORD_W-`EX_CNT_W){1'b0}}, count_leading(a, 1'b1)};
			OP_MUL:  return prod[`EX_WORD_W-1:0];
			OP_MFHI: return m_hi;
			OP_MFLO: return m_lo;
			default: return '0;
		endcase
	endfunction

	`include "tb_mips_ex_tasks.svh"

	task automatic after_reset_reads();
		check_word("res_o.valid", {{(`EX_WORD_W-1){1'b0}}, res.valid}, '0);
		issue_op(OP_MFHI, '0, '0);
		issue_op(OP_MFLO, '0, '0);
		wait_results();
	endtask

	task automatic logic_and_shifts();
		issue_op(OP_OR, $random(seed), $random(seed));
		issue_op(OP_AND, $random(seed), $random(seed));
		issue_op(OP_NOR, $random(seed), $random(seed));
		issue_op(OP_XOR, $random(seed), $random(seed));
		issue_op(OP_SLL, $random(seed), $random(seed));
		issue_op(OP_SRL, $random(seed), $random(seed));
		issue_op(OP_SRA, $random(seed), $random(seed));
		// negative value so ones shift in
		issue_op(OP_SRA, 32'd7, 32'h8000_00f0);
		wait_results();
	endtask

	task automatic add_and_subtract();
		issue_op(OP_ADDU, 32'h7fff_ffff, 32'h1);
		issue_op(OP_SUBU, 32'h8000_0000, 32'h1);
		issue_op(OP_ADD, 32'h7fff_ffff, 32'h1);
		issue_op(OP_SUB, 32'h8000_0000, 32'h1);
		issue_op(OP_ADD, $random(seed), 32'h10);
		issue_op(OP_SUB, 32'hffff_fff0, 32'h5);
		wait_results();
	endtask

	task automatic compares_and_counts();
		issue_op(OP_SLT, 32'hffff_ffff, 32'h1);
		issue_op(OP_SLTU, 32'hffff_ffff, 32'h1);
		issue_op(OP_SLT, 32'h1, 32'hffff_ffff);
		issue_op(OP_SLTU, 32'h1, 32'hffff_ffff);
		issue_op(OP_CLZ, 32'h0, '0);
		issue_op(OP_CLZ, 32'hffff_ffff, '0);
		issue_op(OP_CLO, 32'hffff_ffff, '0);
		issue_op(OP_CLO, 32'h0, '0);
		wait_results();
	endtask

	task automatic multiply_and_forward();
		int      gap;
		alu_op_e mop;
		issue_op(OP_MUL, $random(seed), $random(seed));
		wait_results();
		// gaps 0, 1, 2 and 4 for both signed and unsigned
		for (int i = 0; i < 8; i++) begin
			gap = i / 2;
			if (gap == 3) begin
				gap = 4;
			end
			if (i % 2) begin
				mop = OP_MULTU;
			end else begin
				mop = OP_MULT;
			end
			issue_op(mop, $random(seed), $random(seed));
			idle_cycles(gap);
			issue_op(OP_MFHI, '0, '0);
			issue_op(OP_MFLO, '0, '0);
			wait_results();
		end
	endtask

	task automatic moves_to_hilo();
		issue_op(OP_MTHI, $random(seed), '0);
		issue_op(OP_MFLO, '0, '0);
		issue_op(OP_MFHI, '0, '0);
		issue_op(OP_MTLO, $random(seed), '0);
		issue_op(OP_MFHI, '0, '0);
		issue_op(OP_MFLO, '0, '0);
		wait_results();
	endtask

	initial begin
		rst_n_i = 1'b0;
		req = '0;
		cyc = 0;
		seed = 32'h9698;
		m_hi = '0;
		m_lo = '0;
		next_wd = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n_i = 1'b1;
		after_reset_reads();
		logic_and_shifts();
		add_and_subtract();
		compares_and_counts();
		multiply_and_forward();
		moves_to_hilo();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- include/mips_ex_consts.svh
`ifndef MIPS_EX_CONSTS_SVH
`define MIPS_EX_CONSTS_SVH

// data path word
`define EX_WORD_W 32

// general purpose register index
`define EX_REGADDR_W 5

// shift amount from the low bits of operand 1
`define EX_SHAMT_W 5

// clz/clo result from 0 to 32
`define EX_CNT_W 6

`endif

//--- mips_ex.f
+incdir+include
verilog/mips_ex_pkg.sv
verilog/ex_decode.sv
verilog/ex_alu.sv
verilog/ex_hilo_wb.sv
verilog/mips_ex_top.sv
bench/tb_mips_ex.sv

//--- verilog/ex_alu.sv
`timescale 1ns/1ps
`include "mips_ex_consts.svh"

module ex_alu import mips_ex_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  ex_s1_t                     s1_i,
	input  hilo_wr_t                   wb_hilo_i,
	input  logic [2*`EX_WORD_W-1:0]    hilo_i,
	output ex_s2_t                     s2_o
);

	word_t                     reg1;
	word_t                     reg2;
	logic [`EX_SHAMT_W-1:0]    shamt;
	word_t                     logic_res;
	word_t                     shift_res;
	word_t                     arith_res;
	word_t                     mov_res;
	word_t                     sum;
	logic                      carry;
	logic                      ovf_raw;
	logic                      lt;
	logic [`EX_CNT_W-1:0]      lead_cnt;
	word_t                     mag1;
	word_t                     mag2;
	logic [2*`EX_WORD_W-1:0]   prod_mag;
	logic [2*`EX_WORD_W-1:0]   prod;
	word_t                     hi_fwd;
	word_t                     lo_fwd;
	ex_s2_t                    s2_d;
	ex_s2_t                    s2_q;

	function automatic logic [`EX_CNT_W-1:0] lead_zeros(input word_t v);
		logic [`EX_CNT_W-1:0] cnt;
		logic                 hit;
		cnt = '0;
		hit = 1'b0;
		for (int i = `EX_WORD_W - 1; i >= 0; i--) begin
			if (v[i]) begin
				hit = 1'b1;
			end else if (!hit) begin
				cnt = cnt + 1'b1;
			end
		end
		return cnt;
	endfunction

	assign reg1 = s1_i.req.reg1;
	assign reg2 = s1_i.req.reg2;
	assign shamt = reg1[`EX_SHAMT_W-1:0];

	always_comb begin
		case (s1_i.req.op)
			OP_OR:   logic_res = reg1 | reg2;
			OP_AND:  logic_res = reg1 & reg2;
			OP_NOR:  logic_res = ~(reg1 | reg2);
			default: logic_res = reg1 ^ reg2;
		endcase
	end

	always_comb begin
		case (s1_i.req.op)
			OP_SLL:  shift_res = reg2 << shamt;
			OP_SRL:  shift_res = reg2 >> shamt;
			default: shift_res = word_t'($signed(reg2) >>> shamt);
		endcase
	end

	// one adder for add, sub and both compares
	assign {carry, sum} = {1'b0, reg1} + {1'b0, s1_i.ctrl.subtract ? ~reg2 : reg2}
		+ {{`EX_WORD_W{1'b0}}, s1_i.ctrl.subtract};
	assign ovf_raw = (reg1[`EX_WORD_W-1] == (reg2[`EX_WORD_W-1] ^ s1_i.ctrl.subtract))
		&& (sum[`EX_WORD_W-1] != reg1[`EX_WORD_W-1]);
	// no carry out of a - b means a borrow
	assign lt = s1_i.ctrl.signed_cmp ? (sum[`EX_WORD_W-1] ^ ovf_raw) : ~carry;

	assign lead_cnt = lead_zeros((s1_i.req.op == OP_CLO) ? ~reg1 : reg1);

	always_comb begin
		case (s1_i.req.op)
			OP_SLT, OP_SLTU: arith_res = {{(`EX_WORD_W-1){1'b0}}, lt};
			OP_CLZ, OP_CLO:  arith_res = {{(`EX_WORD_W-`EX_CNT_W){1'b0}}, lead_cnt};
			default:         arith_res = sum;
		endcase
	end

	// multiply magnitudes then restore the sign
	assign mag1 = (s1_i.ctrl.signed_mul && reg1[`EX_WORD_W-1]) ? -reg1 : reg1;
	assign mag2 = (s1_i.ctrl.signed_mul && reg2[`EX_WORD_W-1]) ? -reg2 : reg2;
	assign prod_mag = {{`EX_WORD_W{1'b0}}, mag1} * {{`EX_WORD_W{1'b0}}, mag2};
	assign prod = (s1_i.ctrl.signed_mul && (reg1[`EX_WORD_W-1] ^ reg2[`EX_WORD_W-1]))
		? -prod_mag : prod_mag;

	// youngest pending write wins
	always_comb begin
		if (s2_q.hilo.we) begin
			{hi_fwd, lo_fwd} = {s2_q.hilo.hi, s2_q.hilo.lo};
		end else if (wb_hilo_i.we) begin
			{hi_fwd, lo_fwd} = {wb_hilo_i.hi, wb_hilo_i.lo};
		end else begin
			{hi_fwd, lo_fwd} = hilo_i;
		end
	end

	assign mov_res = (s1_i.req.op == OP_MFHI) ? hi_fwd : lo_fwd;

	always_comb begin
		s2_d.res.valid = s1_i.req.valid;
		s2_d.res.wd = s1_i.req.wd;
		s2_d.res.ovf = s1_i.req.valid & s1_i.ctrl.check_ovf & ovf_raw;
		s2_d.res.wreg = s1_i.req.wreg & ~s2_d.res.ovf;
		case (s1_i.ctrl.sel)
			RES_LOGIC: s2_d.res.wdata = logic_res;
			RES_SHIFT: s2_d.res.wdata = shift_res;
			RES_ARITH: s2_d.res.wdata = arith_res;
			RES_MOV:   s2_d.res.wdata = mov_res;
			RES_MUL:   s2_d.res.wdata = prod[`EX_WORD_W-1:0];
			default:   s2_d.res.wdata = '0;
		endcase
		s2_d.hilo.we = s1_i.ctrl.whilo;
		case (s1_i.ctrl.hilo_src)
			2'd1:    {s2_d.hilo.hi, s2_d.hilo.lo} = {reg1, lo_fwd};
			2'd2:    {s2_d.hilo.hi, s2_d.hilo.lo} = {hi_fwd, reg1};
			default: {s2_d.hilo.hi, s2_d.hilo.lo} = prod;
		endcase
	end

	always_ff @(posedge clk) begin
		s2_q <= s2_d;
		if (!rst_n_i) begin
			s2_q.res.valid <= 1'b0;
			s2_q.res.wreg <= 1'b0;
			s2_q.res.ovf <= 1'b0;
			s2_q.hilo.we <= 1'b0;
		end
	end

	assign s2_o = s2_q;

	// only add and sub are decoded with the overflow check
	a_ovf_checked: assert property (@(posedge clk) disable iff (!rst_n_i)
		s2_q.res.ovf |-> $past((s1_i.req.op == OP_ADD) || (s1_i.req.op == OP_SUB)));

endmodule

//--- verilog/ex_decode.sv
`timescale 1ns/1ps
`include "mips_ex_consts.svh"

module ex_decode import mips_ex_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	input  ex_req_t req_i,
	output ex_s1_t  s1_o
);

	ex_ctrl_t ctrl;
	ex_s1_t   s1_q;

	always_comb begin
		ctrl = '{sel: RES_NONE, default: '0};
		case (req_i.op)
			OP_OR, OP_AND, OP_NOR, OP_XOR: begin
				ctrl.sel = RES_LOGIC;
			end
			OP_SLL, OP_SRL, OP_SRA: begin
				ctrl.sel = RES_SHIFT;
			end
			OP_ADD: begin
				ctrl.sel = RES_ARITH;
				ctrl.check_ovf = 1'b1;
			end
			OP_ADDU, OP_CLZ, OP_CLO: begin
				ctrl.sel = RES_ARITH;
			end
			OP_SUB: begin
				ctrl.sel = RES_ARITH;
				ctrl.subtract = 1'b1;
				ctrl.check_ovf = 1'b1;
			end
			OP_SUBU, OP_SLTU: begin
				ctrl.sel = RES_ARITH;
				ctrl.subtract = 1'b1;
			end
			OP_SLT: begin
				ctrl.sel = RES_ARITH;
				ctrl.subtract = 1'b1;
				ctrl.signed_cmp = 1'b1;
			end
			OP_MUL: begin
				ctrl.sel = RES_MUL;
				ctrl.signed_mul = 1'b1;
			end
			OP_MULT: begin
				ctrl.signed_mul = 1'b1;
				ctrl.whilo = 1'b1;
			end
			OP_MULTU: begin
				ctrl.whilo = 1'b1;
			end
			OP_MFHI, OP_MFLO: begin
				ctrl.sel = RES_MOV;
			end
			OP_MTHI: begin
				ctrl.whilo = 1'b1;
				ctrl.hilo_src = 2'd1;
			end
			OP_MTLO: begin
				ctrl.whilo = 1'b1;
				ctrl.hilo_src = 2'd2;
			end
			default: begin
				ctrl.sel = RES_NONE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		s1_q.req <= req_i;
		s1_q.ctrl <= ctrl;
		// bubbles carry no writes
		s1_q.req.wreg <= req_i.valid & req_i.wreg;
		s1_q.ctrl.whilo <= req_i.valid & ctrl.whilo;
		if (!rst_n_i) begin
			s1_q.req.valid <= 1'b0;
			s1_q.req.wreg <= 1'b0;
			s1_q.ctrl.whilo <= 1'b0;
		end
	end

	assign s1_o = s1_q;

	a_no_nop: assert property (@(posedge clk) disable iff (!rst_n_i)
		req_i.valid |-> req_i.op != OP_NOP);

endmodule

//--- verilog/ex_hilo_wb.sv
`timescale 1ns/1ps
`include "mips_ex_consts.svh"

module ex_hilo_wb import mips_ex_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  ex_s2_t                     s2_i,
	output ex_res_t                    res_o,
	output hilo_wr_t                   wb_hilo_o,
	output logic [2*`EX_WORD_W-1:0]    hilo_o
);

	ex_res_t  res_q;
	hilo_wr_t wb_hilo_q;
	word_t    hi_q;
	word_t    lo_q;

	always_ff @(posedge clk) begin
		res_q <= s2_i.res;
		wb_hilo_q <= s2_i.hilo;
		if (!rst_n_i) begin
			res_q.valid <= 1'b0;
			res_q.wreg <= 1'b0;
			res_q.ovf <= 1'b0;
			wb_hilo_q.we <= 1'b0;
		end
	end

	// commit one edge after the result leaves
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (wb_hilo_q.we) begin
			hi_q <= wb_hilo_q.hi;
			lo_q <= wb_hilo_q.lo;
		end
	end

	assign res_o = res_q;
	assign wb_hilo_o = wb_hilo_q;
	assign hilo_o = {hi_q, lo_q};

	a_we_has_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_hilo_q.we |-> res_q.valid);

endmodule

//--- verilog/mips_ex_pkg.sv
`include "mips_ex_consts.svh"

package mips_ex_pkg;

	typedef logic [`EX_WORD_W-1:0] word_t;
	typedef logic [`EX_REGADDR_W-1:0] regaddr_t;

	typedef enum logic [4:0] {
		OP_NOP, OP_OR, OP_AND, OP_NOR, OP_XOR,
		OP_SLL, OP_SRL, OP_SRA,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
		OP_CLZ, OP_CLO,
		OP_MUL, OP_MULT, OP_MULTU,
		OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO
	} alu_op_e;

	typedef enum logic [2:0] {
		RES_LOGIC, RES_SHIFT, RES_ARITH, RES_MOV, RES_MUL, RES_NONE
	} res_sel_e;

	typedef struct packed {
		logic     valid;
		alu_op_e  op;
		word_t    reg1;
		word_t    reg2;
		regaddr_t wd;
		logic     wreg;
	} ex_req_t;

	typedef struct packed {
		res_sel_e   sel;
		logic       subtract;
		logic       signed_cmp;
		logic       signed_mul;
		logic       check_ovf;
		logic       whilo;
		// 0 multiply, 1 reg1 to hi, 2 reg1 to lo
		logic [1:0] hilo_src;
	} ex_ctrl_t;

	typedef struct packed {
		ex_req_t  req;
		ex_ctrl_t ctrl;
	} ex_s1_t;

	typedef struct packed {
		logic  we;
		word_t hi;
		word_t lo;
	} hilo_wr_t;

	typedef struct packed {
		logic     valid;
		regaddr_t wd;
		logic     wreg;
		word_t    wdata;
		logic     ovf;
	} ex_res_t;

	typedef struct packed {
		ex_res_t  res;
		hilo_wr_t hilo;
	} ex_s2_t;

endpackage

//--- verilog/mips_ex_top.sv
`timescale 1ns/1ps
`include "mips_ex_consts.svh"

module mips_ex_top import mips_ex_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	input  ex_req_t req_i,
	output ex_res_t res_o
);

	ex_s1_t                    s1;
	ex_s2_t                    s2;
	hilo_wr_t                  wb_hilo;
	logic [2*`EX_WORD_W-1:0]   hilo;

	ex_decode u_decode (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (req_i),
		.s1_o    (s1)
	);

	// hilo forwarding comes back from the last stage
	ex_alu u_alu (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.s1_i      (s1),
		.wb_hilo_i (wb_hilo),
		.hilo_i    (hilo),
		.s2_o      (s2)
	);

	ex_hilo_wb u_hilo_wb (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.s2_i      (s2),
		.res_o     (res_o),
		.wb_hilo_o (wb_hilo),
		.hilo_o    (hilo)
	);

endmodule
